// File: hdl/rs_config_pkg.sv
`default_nettype none

// sizing of the reservation station
package rs_config_pkg;

    // default number of entries in the circular array
    localparam int DEFAULT_ENT_NUM = 4;

    // pointer width, log2 of the entry count
    localparam int DEFAULT_ENT_SEL = 2;

    // operand value width
    localparam int DATA_W = 32;

    // result tag width
    // a waiting operand keeps its tag in the low bits of the value field
    localparam int TAG_W = 6;

endpackage

`default_nettype wire

// File: hdl/rs_uop_pkg.sv
`default_nettype none

// micro-op encoding as seen by the station
package rs_uop_pkg;

    // operations of the execution pipe
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5
    } uop_opcode_e;

    // max micro-ops written per cycle
    // request count runs 0..DISPATCH_W
    localparam int DISPATCH_W = 2;

endpackage

`default_nettype wire

// File: hdl/entry_searcher.sv
`timescale 1ns/1ns
`default_nettype none

module entry_searcher #(
    parameter int ENT_NUM = rs_config_pkg::DEFAULT_ENT_NUM,
    parameter int ENT_SEL = rs_config_pkg::DEFAULT_ENT_SEL
) (
    input  wire [ENT_NUM-1:0] begin_entry_i,
    input  wire [ENT_NUM-1:0] end_entry_i,
    output logic [ENT_SEL-1:0] begin_select_o,
    output logic [ENT_SEL-1:0] end_select_o,
    output logic               begin_en_o,
    output logic               end_en_o
);

    // lowest set bit, scanning up from index 0
    always_comb begin
        logic found;
        found = 1'b0;
        begin_select_o = '0;
        for (int i = 0; i < ENT_NUM; i++) begin
            if (!found && begin_entry_i[i]) begin
                begin_select_o = ENT_SEL'(i);
                found = 1'b1;
            end
        end
    end

    // last index of the first run of ones
    always_comb begin
        logic in_run;
        logic run_done;
        in_run = 1'b0;
        run_done = 1'b0;
        end_select_o = '0;
        for (int i = 0; i < ENT_NUM; i++) begin
            if (!run_done) begin
                if (end_entry_i[i]) begin
                    end_select_o = ENT_SEL'(i);
                    in_run = 1'b1;
                end else if (in_run) begin
                    run_done = 1'b1;
                end
            end
        end
    end

    assign begin_en_o = |begin_entry_i;
    assign end_en_o = |end_entry_i;

endmodule

`default_nettype wire

// File: hdl/inorder_alloc_issue_unit.sv
`timescale 1ns/1ns
`default_nettype none

module inorder_alloc_issue_unit #(
    parameter int ENT_NUM = rs_config_pkg::DEFAULT_ENT_NUM,
    parameter int ENT_SEL = rs_config_pkg::DEFAULT_ENT_SEL
) (
    input  wire                clk_i,
    input  wire                reset_i,
    input  wire [$clog2(rs_uop_pkg::DISPATCH_W+1)-1:0] req_num_i,
    input  wire [ENT_NUM-1:0]  busy_vector_i,
    input  wire [ENT_NUM-1:0]  ready_vector_i,
    input  wire                dp_stall_i,
    input  wire                dp_kill_i,
    output logic [ENT_SEL-1:0] alloc_ptr_o,
    output logic               allocatable_o,
    output logic [ENT_SEL-1:0] issue_ptr_o,
    output logic               issue_valid_o
);

    localparam logic [ENT_SEL-1:0] LAST_ENT = ENT_SEL'(ENT_NUM - 1);

    logic [ENT_SEL-1:0] free_end;
    logic               any_free;
    logic [ENT_SEL-1:0] busy_begin;
    logic [ENT_SEL-1:0] busy_end;
    logic               any_busy;
    logic               wrapped;
    logic [ENT_SEL-1:0] alloc_ptr_inc;
    logic [ENT_SEL:0]   ptr_sum;
    logic [ENT_SEL-1:0] alloc_ptr_next;

    // first run of free entries
    entry_searcher #(.ENT_NUM(ENT_NUM), .ENT_SEL(ENT_SEL)) u_free_search (
        .begin_entry_i  (~busy_vector_i),
        .end_entry_i    (~busy_vector_i),
        .begin_select_o (),
        .end_select_o   (free_end),
        .begin_en_o     (),
        .end_en_o       (any_free)
    );

    // first run of busy entries
    entry_searcher #(.ENT_NUM(ENT_NUM), .ENT_SEL(ENT_SEL)) u_busy_search (
        .begin_entry_i  (busy_vector_i),
        .end_entry_i    (busy_vector_i),
        .begin_select_o (busy_begin),
        .end_select_o   (busy_end),
        .begin_en_o     (any_busy),
        .end_en_o       ()
    );

    // busy run starts at 0 and stops short of the top, yet the top is busy
    // so the occupied region wraps through index 0
    assign wrapped = any_busy && (busy_begin == '0) && (busy_end != LAST_ENT)
                     && busy_vector_i[ENT_NUM-1];

    // oldest entry: full -> alloc_ptr, wrapped -> past the free gap
    assign issue_ptr_o = !any_free ? alloc_ptr_o :
                         wrapped   ? ENT_SEL'(free_end + 1'b1) :
                                     busy_begin;

    assign issue_valid_o = any_busy & ready_vector_i[issue_ptr_o];

    assign alloc_ptr_inc = (alloc_ptr_o == LAST_ENT) ? '0 : ENT_SEL'(alloc_ptr_o + 1'b1);

    always_comb begin
        case (req_num_i)
            2'd0: allocatable_o = 1'b1;
            2'd1: allocatable_o = ~busy_vector_i[alloc_ptr_o];
            default: allocatable_o = ~busy_vector_i[alloc_ptr_o] & ~busy_vector_i[alloc_ptr_inc];
        endcase
    end

    // pointer advance modulo ENT_NUM
    assign ptr_sum = {1'b0, alloc_ptr_o} + (ENT_SEL+1)'(req_num_i);
    assign alloc_ptr_next = (ptr_sum >= (ENT_SEL+1)'(ENT_NUM)) ?
                            ENT_SEL'(ptr_sum - (ENT_SEL+1)'(ENT_NUM)) : ENT_SEL'(ptr_sum);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            alloc_ptr_o <= '0;
        end else if (!dp_stall_i && !dp_kill_i) begin
            alloc_ptr_o <= alloc_ptr_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rs_entry_array.sv
`timescale 1ns/1ns
`default_nettype none

module rs_entry_array #(
    parameter int ENT_NUM = rs_config_pkg::DEFAULT_ENT_NUM,
    parameter int ENT_SEL = rs_config_pkg::DEFAULT_ENT_SEL
) (
    input  wire                clk_i,
    input  wire                reset_i,
    // write side
    input  wire [ENT_SEL-1:0]  alloc_ptr_i,
    input  wire                write_en_i,
    input  wire [$clog2(rs_uop_pkg::DISPATCH_W+1)-1:0] req_num_i,
    input  var rs_uop_pkg::uop_opcode_e dp0_opcode_i,
    input  wire [rs_config_pkg::TAG_W-1:0]  dp0_dst_tag_i,
    input  wire                             dp0_src_a_ready_i,
    input  wire [rs_config_pkg::DATA_W-1:0] dp0_src_a_i,
    input  wire                             dp0_src_b_ready_i,
    input  wire [rs_config_pkg::DATA_W-1:0] dp0_src_b_i,
    input  var rs_uop_pkg::uop_opcode_e dp1_opcode_i,
    input  wire [rs_config_pkg::TAG_W-1:0]  dp1_dst_tag_i,
    input  wire                             dp1_src_a_ready_i,
    input  wire [rs_config_pkg::DATA_W-1:0] dp1_src_a_i,
    input  wire                             dp1_src_b_ready_i,
    input  wire [rs_config_pkg::DATA_W-1:0] dp1_src_b_i,
    // flush and writeback bus
    input  wire                             kill_i,
    input  wire                             wb_valid_i,
    input  wire [rs_config_pkg::TAG_W-1:0]  wb_tag_i,
    input  wire [rs_config_pkg::DATA_W-1:0] wb_data_i,
    // issue side
    input  wire [ENT_SEL-1:0]  issue_ptr_i,
    input  wire                issue_valid_i,
    input  wire                iss_ready_i,
    output logic [ENT_NUM-1:0] busy_vector_o,
    output logic [ENT_NUM-1:0] ready_vector_o,
    output logic               iss_valid_o,
    output rs_uop_pkg::uop_opcode_e iss_opcode_o,
    output logic [rs_config_pkg::TAG_W-1:0]  iss_dst_tag_o,
    output logic [rs_config_pkg::DATA_W-1:0] iss_src_a_o,
    output logic [rs_config_pkg::DATA_W-1:0] iss_src_b_o,
    output logic                             credit_return_o
);

    import rs_config_pkg::*;
    import rs_uop_pkg::*;

    localparam logic [ENT_SEL-1:0] LAST_ENT = ENT_SEL'(ENT_NUM - 1);

    // per-entry payload
    uop_opcode_e        opcode_q [ENT_NUM];
    logic [TAG_W-1:0]   dst_tag_q [ENT_NUM];
    logic [DATA_W-1:0]  src_a_q [ENT_NUM];
    logic [DATA_W-1:0]  src_b_q [ENT_NUM];
    logic [ENT_NUM-1:0] src_a_rdy_q;
    logic [ENT_NUM-1:0] src_b_rdy_q;
    logic [ENT_NUM-1:0] busy_q;

    logic [ENT_SEL-1:0] slot1_ptr;
    logic               slot0_we;
    logic               slot1_we;
    logic               issue_fire;
    logic [DATA_W:0]    dp0_a;
    logic [DATA_W:0]    dp0_b;
    logic [DATA_W:0]    dp1_a;
    logic [DATA_W:0]    dp1_b;

    // writeback capture for one operand, result is {ready, value}
    function automatic logic [DATA_W:0] snoop(input logic rdy, input logic [DATA_W-1:0] val);
        if (!rdy && wb_valid_i && (val[TAG_W-1:0] == wb_tag_i)) begin
            return {1'b1, wb_data_i};
        end
        return {rdy, val};
    endfunction

    assign slot1_ptr = (alloc_ptr_i == LAST_ENT) ? '0 : ENT_SEL'(alloc_ptr_i + 1'b1);
    assign slot0_we = write_en_i && (req_num_i != '0);
    assign slot1_we = write_en_i && (req_num_i == DISPATCH_W);
    assign issue_fire = issue_valid_i && iss_ready_i;

    // incoming operands also see the bus in their dispatch cycle
    assign dp0_a = snoop(dp0_src_a_ready_i, dp0_src_a_i);
    assign dp0_b = snoop(dp0_src_b_ready_i, dp0_src_b_i);
    assign dp1_a = snoop(dp1_src_a_ready_i, dp1_src_a_i);
    assign dp1_b = snoop(dp1_src_b_ready_i, dp1_src_b_i);

    always_ff @(posedge clk_i) begin
        if (reset_i || kill_i) begin
            busy_q <= '0;
        end else begin
            // writes only target free entries, issue only a busy one
            if (issue_fire) begin
                busy_q[issue_ptr_i] <= 1'b0;
            end
            if (slot0_we) begin
                busy_q[alloc_ptr_i] <= 1'b1;
            end
            if (slot1_we) begin
                busy_q[slot1_ptr] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int e = 0; e < ENT_NUM; e++) begin
            {src_a_rdy_q[e], src_a_q[e]} <= snoop(src_a_rdy_q[e], src_a_q[e]);
            {src_b_rdy_q[e], src_b_q[e]} <= snoop(src_b_rdy_q[e], src_b_q[e]);
        end
        if (slot0_we) begin
            opcode_q[alloc_ptr_i] <= dp0_opcode_i;
            dst_tag_q[alloc_ptr_i] <= dp0_dst_tag_i;
            {src_a_rdy_q[alloc_ptr_i], src_a_q[alloc_ptr_i]} <= dp0_a;
            {src_b_rdy_q[alloc_ptr_i], src_b_q[alloc_ptr_i]} <= dp0_b;
        end
        if (slot1_we) begin
            opcode_q[slot1_ptr] <= dp1_opcode_i;
            dst_tag_q[slot1_ptr] <= dp1_dst_tag_i;
            {src_a_rdy_q[slot1_ptr], src_a_q[slot1_ptr]} <= dp1_a;
            {src_b_rdy_q[slot1_ptr], src_b_q[slot1_ptr]} <= dp1_b;
        end
    end

    assign busy_vector_o = busy_q;
    assign ready_vector_o = busy_q & src_a_rdy_q & src_b_rdy_q;

    // read-out of the oldest entry
    assign iss_valid_o = issue_valid_i;
    assign iss_opcode_o = opcode_q[issue_ptr_i];
    assign iss_dst_tag_o = dst_tag_q[issue_ptr_i];
    assign iss_src_a_o = src_a_q[issue_ptr_i];
    assign iss_src_b_o = src_b_q[issue_ptr_i];

    // one credit per entry leaving
    assign credit_return_o = issue_fire;

endmodule

`default_nettype wire

// File: hdl/inorder_rs_top.sv
`timescale 1ns/1ns
`default_nettype none

module inorder_rs_top #(
    parameter int ENT_NUM = rs_config_pkg::DEFAULT_ENT_NUM,
    parameter int ENT_SEL = rs_config_pkg::DEFAULT_ENT_SEL
) (
    input  wire                             clk_i,
    input  wire                             reset_i,
    // dispatcher
    input  wire [$clog2(rs_uop_pkg::DISPATCH_W+1)-1:0] dp_req_num_i,
    input  var rs_uop_pkg::uop_opcode_e     dp0_opcode_i,
    input  wire [rs_config_pkg::TAG_W-1:0]  dp0_dst_tag_i,
    input  wire                             dp0_src_a_ready_i,
    input  wire [rs_config_pkg::DATA_W-1:0] dp0_src_a_i,
    input  wire                             dp0_src_b_ready_i,
    input  wire [rs_config_pkg::DATA_W-1:0] dp0_src_b_i,
    input  var rs_uop_pkg::uop_opcode_e     dp1_opcode_i,
    input  wire [rs_config_pkg::TAG_W-1:0]  dp1_dst_tag_i,
    input  wire                             dp1_src_a_ready_i,
    input  wire [rs_config_pkg::DATA_W-1:0] dp1_src_a_i,
    input  wire                             dp1_src_b_ready_i,
    input  wire [rs_config_pkg::DATA_W-1:0] dp1_src_b_i,
    input  wire                             dp_stall_i,
    input  wire                             dp_kill_i,
    // writeback bus
    input  wire                             wb_valid_i,
    input  wire [rs_config_pkg::TAG_W-1:0]  wb_tag_i,
    input  wire [rs_config_pkg::DATA_W-1:0] wb_data_i,
    // issue port
    input  wire                             iss_ready_i,
    output logic                            iss_valid_o,
    output rs_uop_pkg::uop_opcode_e         iss_opcode_o,
    output logic [rs_config_pkg::TAG_W-1:0]  iss_dst_tag_o,
    output logic [rs_config_pkg::DATA_W-1:0] iss_src_a_o,
    output logic [rs_config_pkg::DATA_W-1:0] iss_src_b_o,
    output logic                             credit_return_o
);

    logic [ENT_NUM-1:0] busy_vector;
    logic [ENT_NUM-1:0] ready_vector;
    logic [ENT_SEL-1:0] alloc_ptr;
    logic               allocatable;
    logic [ENT_SEL-1:0] issue_ptr;
    logic               issue_valid;
    logic               write_en;

    // array write also guarded by the room check
    assign write_en = allocatable & ~dp_stall_i & ~dp_kill_i;

    // dispatch, writeback and issue ports share names with the array
    rs_entry_array #(.ENT_NUM(ENT_NUM), .ENT_SEL(ENT_SEL)) u_entry_array (
        .alloc_ptr_i    (alloc_ptr),
        .write_en_i     (write_en),
        .req_num_i      (dp_req_num_i),
        .kill_i         (dp_kill_i),
        .issue_ptr_i    (issue_ptr),
        .issue_valid_i  (issue_valid),
        .busy_vector_o  (busy_vector),
        .ready_vector_o (ready_vector),
        .*
    );

    inorder_alloc_issue_unit #(.ENT_NUM(ENT_NUM), .ENT_SEL(ENT_SEL)) u_alloc_issue (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .req_num_i      (dp_req_num_i),
        .busy_vector_i  (busy_vector),
        .ready_vector_i (ready_vector),
        .dp_stall_i     (dp_stall_i),
        .dp_kill_i      (dp_kill_i),
        .alloc_ptr_o    (alloc_ptr),
        .allocatable_o  (allocatable),
        .issue_ptr_o    (issue_ptr),
        .issue_valid_o  (issue_valid)
    );

endmodule

`default_nettype wire

// File: test/rs_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rs_tb;

    import rs_config_pkg::*;
    import rs_uop_pkg::*;

    localparam int ENT_NUM = DEFAULT_ENT_NUM;
    localparam int ENT_SEL = DEFAULT_ENT_SEL;
    localparam int CLK_PERIOD = 20;
    // upper bound on micro-ops sent over all tests
    localparam int NUM_UOPS = 64;
    localparam int WATCHDOG_NS = NUM_UOPS * 40 * CLK_PERIOD;

    typedef struct packed {
        uop_opcode_e       opcode;
        logic [TAG_W-1:0]  dst;
        logic              a_rdy;
        logic [DATA_W-1:0] a;
        logic              b_rdy;
        logic [DATA_W-1:0] b;
    } uop_t;

    logic              clk_i;
    logic              reset_i;
    logic [1:0]        dp_req_num_i;
    uop_opcode_e       dp0_opcode_i;
    logic [TAG_W-1:0]  dp0_dst_tag_i;
    logic              dp0_src_a_ready_i;
    logic [DATA_W-1:0] dp0_src_a_i;
    logic              dp0_src_b_ready_i;
    logic [DATA_W-1:0] dp0_src_b_i;
    uop_opcode_e       dp1_opcode_i;
    logic [TAG_W-1:0]  dp1_dst_tag_i;
    logic              dp1_src_a_ready_i;
    logic [DATA_W-1:0] dp1_src_a_i;
    logic              dp1_src_b_ready_i;
    logic [DATA_W-1:0] dp1_src_b_i;
    logic              dp_stall_i;
    logic              dp_kill_i;
    logic              wb_valid_i;
    logic [TAG_W-1:0]  wb_tag_i;
    logic [DATA_W-1:0] wb_data_i;
    logic              iss_ready_i;
    logic              iss_valid_o;
    uop_opcode_e       iss_opcode_o;
    logic [TAG_W-1:0]  iss_dst_tag_o;
    logic [DATA_W-1:0] iss_src_a_o;
    logic [DATA_W-1:0] iss_src_b_o;
    logic              credit_return_o;

    // reference model: program-order queue plus written-back tag values
    uop_t              model_q[$];
    logic [DATA_W-1:0] wb_val [2**TAG_W];
    logic              wb_seen [2**TAG_W];
    logic [TAG_W-1:0]  pending_tags[$];
    logic [TAG_W-1:0]  next_tag;
    logic [15:0]       lfsr;
    int                credits;
    int                errors;
    int                checks;
    int                issued;
    logic              hold_prev;
    uop_t              held;

    inorder_rs_top #(.ENT_NUM(ENT_NUM), .ENT_SEL(ENT_SEL)) i_dut (.*);

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // head of the queue with written-back operands filled in
    function automatic uop_t expected_uop();
        uop_t u;
        u = model_q[0];
        if (!u.a_rdy && wb_seen[u.a[TAG_W-1:0]]) begin
            u.a = wb_val[u.a[TAG_W-1:0]];
            u.a_rdy = 1'b1;
        end
        if (!u.b_rdy && wb_seen[u.b[TAG_W-1:0]]) begin
            u.b = wb_val[u.b[TAG_W-1:0]];
            u.b_rdy = 1'b1;
        end
        return u;
    endfunction

    function automatic uop_t slot_uop(input logic slot);
        if (!slot) begin
            return {dp0_opcode_i, dp0_dst_tag_i, dp0_src_a_ready_i, dp0_src_a_i,
                    dp0_src_b_ready_i, dp0_src_b_i};
        end
        return {dp1_opcode_i, dp1_dst_tag_i, dp1_src_a_ready_i, dp1_src_a_i,
                dp1_src_b_ready_i, dp1_src_b_i};
    endfunction

    task automatic compare_value(input string name, input logic [DATA_W-1:0] got,
                                 input logic [DATA_W-1:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error: %s = %h, expected %h at %0t ns", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s at %0t ns", what, $time);
            errors++;
        end
    endtask

    task automatic take_tag(output logic [TAG_W-1:0] t);
        t = next_tag;
        wb_seen[t] = 1'b0;
        next_tag = (next_tag == TAG_W'(2**TAG_W - 1)) ? TAG_W'(1) : next_tag + 1'b1;
    endtask

    // waiting operand carries its tag in the low bits
    task automatic make_operand(input logic wait_tag, output logic rdy,
                                output logic [DATA_W-1:0] val);
        logic [TAG_W-1:0] t;
        logic [31:0]      r;
        if (wait_tag) begin
            take_tag(t);
            pending_tags.push_back(t);
            val = DATA_W'(t);
            rdy = 1'b0;
        end else begin
            draw_bits(DATA_W, r);
            val = r;
            rdy = 1'b1;
        end
    endtask

    task automatic drive_slot(input int slot, input uop_t u);
        if (slot == 0) begin
            dp0_opcode_i = u.opcode;
            dp0_dst_tag_i = u.dst;
            dp0_src_a_ready_i = u.a_rdy;
            dp0_src_a_i = u.a;
            dp0_src_b_ready_i = u.b_rdy;
            dp0_src_b_i = u.b;
        end else begin
            dp1_opcode_i = u.opcode;
            dp1_dst_tag_i = u.dst;
            dp1_src_a_ready_i = u.a_rdy;
            dp1_src_a_i = u.a;
            dp1_src_b_ready_i = u.b_rdy;
            dp1_src_b_i = u.b;
        end
    endtask

    task automatic put_uops(input int n, input logic a_wait, input logic b_wait,
                            input logic stall);
        uop_t        u;
        logic [31:0] r;
        for (int s = 0; s < n; s++) begin
            draw_bits(3, r);
            u.opcode = uop_opcode_e'(3'(r % 6));
            take_tag(u.dst);
            make_operand(a_wait, u.a_rdy, u.a);
            make_operand(b_wait, u.b_rdy, u.b);
            drive_slot(s, u);
        end
        dp_req_num_i = 2'(n);
        dp_stall_i = stall;
        if (!stall) begin
            credits -= n;
        end
    endtask

    task automatic put_wb(input logic [TAG_W-1:0] tag);
        logic [31:0] r;
        draw_bits(DATA_W, r);
        wb_valid_i = 1'b1;
        wb_tag_i = tag;
        wb_data_i = r;
    endtask

    // inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #2;
        dp_req_num_i = '0;
        dp_stall_i = 1'b0;
        dp_kill_i = 1'b0;
        wb_valid_i = 1'b0;
    endtask

    task automatic send(input int n, input logic a_wait, input logic b_wait);
        next_cycle();
        while (credits < n) begin
            next_cycle();
        end
        put_uops(n, a_wait, b_wait, 1'b0);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        next_cycle();
        iss_ready_i = 1'b1;
        while (model_q.size() != 0 && waited < 100) begin
            next_cycle();
            waited++;
        end
        expect_true(model_q.size() == 0, "drain timed out with micro-ops still in the station");
        @(negedge clk_i);
        expect_true(!iss_valid_o, "issue port still valid after the station drained");
        expect_true(credits == ENT_NUM, "credits not fully returned after drain");
    endtask

    task automatic report_test(input string name, input int start);
        $display("test %s: %0d errors", name, errors - start);
    endtask

    // comparison process, sampled mid-cycle where inputs and outputs are settled
    always @(negedge clk_i) begin
        uop_t exp_u;
        logic fire;
        logic exp_valid;
        fire = iss_valid_o && iss_ready_i;
        if (reset_i) begin
            hold_prev = 1'b0;
        end else begin
            // the head may leave once both operands are known to the model
            exp_valid = 1'b0;
            if (model_q.size() != 0) begin
                exp_u = expected_uop();
                exp_valid = exp_u.a_rdy && exp_u.b_rdy;
            end
            compare_value("iss_valid_o", DATA_W'(iss_valid_o), DATA_W'(exp_valid));
            if (hold_prev) begin
                expect_true(iss_valid_o, "issue valid dropped under back-pressure");
                compare_value("iss_opcode_o", DATA_W'(iss_opcode_o), DATA_W'(held.opcode));
                compare_value("iss_dst_tag_o", DATA_W'(iss_dst_tag_o), DATA_W'(held.dst));
                compare_value("iss_src_a_o", iss_src_a_o, held.a);
                compare_value("iss_src_b_o", iss_src_b_o, held.b);
            end
            compare_value("credit_return_o", DATA_W'(credit_return_o),
                          DATA_W'(exp_valid && iss_ready_i));
            // credits from a kill cycle are dropped
            if (credit_return_o && !dp_kill_i) begin
                credits++;
            end
            if (fire && !dp_kill_i) begin
                if (model_q.size() == 0) begin
                    expect_true(1'b0, "issue with no micro-op outstanding");
                end else begin
                    compare_value("iss_opcode_o", DATA_W'(iss_opcode_o), DATA_W'(exp_u.opcode));
                    compare_value("iss_dst_tag_o", DATA_W'(iss_dst_tag_o), DATA_W'(exp_u.dst));
                    compare_value("iss_src_a_o", iss_src_a_o, exp_u.a);
                    compare_value("iss_src_b_o", iss_src_b_o, exp_u.b);
                    void'(model_q.pop_front());
                    issued++;
                end
            end
            if (wb_valid_i) begin
                wb_val[wb_tag_i] = wb_data_i;
                wb_seen[wb_tag_i] = 1'b1;
            end
            if (dp_kill_i) begin
                model_q.delete();
            end else if (!dp_stall_i && dp_req_num_i != 0) begin
                model_q.push_back(slot_uop(1'b0));
                if (dp_req_num_i == 2) begin
                    model_q.push_back(slot_uop(1'b1));
                end
            end
            hold_prev = iss_valid_o && !iss_ready_i && !dp_kill_i;
            held.opcode = iss_opcode_o;
            held.dst = iss_dst_tag_o;
            held.a = iss_src_a_o;
            held.b = iss_src_b_o;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int          start;
        int          base;
        logic [31:0] r;
        lfsr = 16'd30952;
        next_tag = TAG_W'(1);
        credits = ENT_NUM;
        errors = 0;
        checks = 0;
        issued = 0;
        hold_prev = 1'b0;
        for (int t = 0; t < 2**TAG_W; t++) begin
            wb_seen[t] = 1'b0;
            wb_val[t] = '0;
        end
        reset_i = 1'b1;
        drive_slot(0, '0);
        drive_slot(1, '0);
        dp_req_num_i = '0;
        dp_stall_i = 1'b0;
        dp_kill_i = 1'b0;
        wb_valid_i = 1'b0;
        wb_tag_i = '0;
        wb_data_i = '0;
        iss_ready_i = 1'b0;
        repeat (4) @(posedge clk_i);
        #2;
        reset_i = 1'b0;

        // idle after reset, then fill with the port blocked
        start = errors;
        @(negedge clk_i);
        expect_true(!iss_valid_o && !credit_return_o, "issue or credit active after reset");
        base = issued;
        while (credits > 0) begin
            next_cycle();
            put_uops(1, 1'b0, 1'b0, 1'b0);
        end
        next_cycle();
        @(negedge clk_i);
        expect_true(iss_valid_o, "full station offers no oldest entry");
        drain();
        expect_true(issued - base == ENT_NUM,
                    "station did not take and return exactly its entry count");
        report_test("reset and capacity", start);

        // mixed one- and two-wide dispatch, pointer wraps several times
        start = errors;
        repeat (12) begin
            draw_bits(1, r);
            send(int'(r[0]) + 1, 1'b0, 1'b0);
            draw_bits(2, r);
            repeat (r[1:0]) next_cycle();
        end
        drain();
        report_test("in-order wraparound", start);

        // older waiting entry blocks younger ready ones
        start = errors;
        send(1, 1'b1, 1'b0);
        send(2, 1'b0, 1'b0);
        repeat (4) next_cycle();
        @(negedge clk_i);
        expect_true(!iss_valid_o, "issue valid while the oldest entry waits on a tag");
        next_cycle();
        put_wb(pending_tags.pop_front());
        // writeback landing in the dispatch cycle
        send(1, 1'b1, 1'b1);
        put_wb(pending_tags.pop_front());
        next_cycle();
        next_cycle();
        put_wb(pending_tags.pop_front());
        drain();
        report_test("wakeup", start);

        start = errors;
        next_cycle();
        iss_ready_i = 1'b0;
        send(2, 1'b0, 1'b0);
        send(1, 1'b0, 1'b0);
        repeat (5) next_cycle();
        @(negedge clk_i);
        expect_true(iss_valid_o, "no issue request while held by back-pressure");
        repeat (12) begin
            next_cycle();
            draw_bits(1, r);
            iss_ready_i = r[0];
            draw_bits(1, r);
            if (credits > 0 && r[0]) begin
                put_uops(1, 1'b0, 1'b0, 1'b0);
            end
        end
        drain();
        report_test("back-pressure", start);

        // flush a full station, then refill
        start = errors;
        next_cycle();
        iss_ready_i = 1'b0;
        send(2, 1'b0, 1'b0);
        send(2, 1'b0, 1'b0);
        next_cycle();
        dp_kill_i = 1'b1;
        credits = ENT_NUM;
        pending_tags.delete();
        next_cycle();
        @(negedge clk_i);
        expect_true(!iss_valid_o, "entries still offered after kill");
        next_cycle();
        iss_ready_i = 1'b1;
        send(1, 1'b0, 1'b0);
        send(2, 1'b0, 1'b0);
        drain();
        report_test("kill", start);

        start = errors;
        base = issued;
        next_cycle();
        put_uops(2, 1'b0, 1'b0, 1'b1);
        next_cycle();
        put_uops(1, 1'b0, 1'b0, 1'b1);
        send(1, 1'b0, 1'b0);
        next_cycle();
        put_uops(2, 1'b0, 1'b0, 1'b1);
        send(2, 1'b0, 1'b0);
        drain();
        expect_true(issued - base == 3, "stalled requests reached the issue port");
        report_test("stall", start);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hdl/rs_config_pkg.sv
hdl/rs_uop_pkg.sv
hdl/entry_searcher.sv
hdl/inorder_alloc_issue_unit.sv
hdl/rs_entry_array.sv
hdl/inorder_rs_top.sv
test/rs_tb.sv

// File: run.sh
#!/bin/sh
# build and run the reservation station testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rs_tb \
    -f src.f -o rs_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/rs_sim > sim.log 2>&1
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && exit 1
grep -qF "*** TEST PASSED ***" sim.log || { echo "simulation ended without a verdict"; exit 1; }
exit 0
